//--- div_pkg.sv
`default_nettype none

package div_pkg;

    localparam int DATA_W = 32;     // operand width
    localparam int STEP_W = 6;      // iteration counter width

    // operation select carried with each request
    typedef enum logic {
        DIV_UNSIGNED = 1'b0,
        DIV_SIGNED   = 1'b1
    } div_op_e;

    typedef enum logic [1:0] {
        CORE_IDLE = 2'd0,           // waiting for start
        CORE_RUN  = 2'd1,           // shift-subtract steps
        CORE_DONE = 2'd2            // result valid, one cycle
    } core_state_e;

    typedef struct packed {
        div_op_e           op;
        logic [DATA_W-1:0] dividend;
        logic [DATA_W-1:0] divisor;
    } div_req_t;

    typedef struct packed {
        logic [DATA_W-1:0] quotient;
        logic [DATA_W-1:0] remainder;
        logic              div_by_zero;
    } div_rsp_t;

endpackage

`default_nettype wire

//--- div_iter_core.sv
`timescale 1ns/1ps
`default_nettype none

module div_iter_core import div_pkg::*; (
    input  wire logic              clk,
    input  wire logic              arst_n,

    input  wire logic              start,       // load pulse, sampled in idle only
    input  wire logic [DATA_W-1:0] dividend,
    input  wire logic [DATA_W-1:0] divisor,

    output logic [DATA_W-1:0]      quotient,
    output logic [DATA_W-1:0]      remainder,
    output logic                   div_by_zero,
    output logic                   core_done    // high for the one CORE_DONE cycle
);

    core_state_e       state;
    logic [STEP_W-1:0] step;

    logic [DATA_W-1:0] quo_q;       // dividend bits shift out, quotient bits shift in
    logic [DATA_W-1:0] rem_q;       // partial remainder
    logic [DATA_W-1:0] dvs_q;
    logic              dbz_q;

    logic [DATA_W:0]   shifted;
    logic [DATA_W:0]   trial;
    logic              fits;
    logic              load;

    assign load = (state == CORE_IDLE) && start;

    // one restoring step: bring down the next dividend bit and try a subtract
    assign shifted = {rem_q, quo_q[DATA_W-1]};
    assign trial   = shifted - {1'b0, dvs_q};
    assign fits    = ~trial[DATA_W];    // no borrow, divisor goes in

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= CORE_IDLE;
            step  <= '0;
        end else begin
            case (state)
                CORE_IDLE: begin
                    if (start) begin
                        state <= CORE_RUN;
                        step  <= '0;
                    end
                end
                CORE_RUN: begin
                    step <= step + 1'b1;
                    if (step == STEP_W'(DATA_W - 1)) begin
                        state <= CORE_DONE;     // 32nd step taken
                    end
                end
                CORE_DONE: begin
                    state <= CORE_IDLE;
                end
                default: begin
                    state <= CORE_IDLE;
                end
            endcase
        end
    end

    // datapath, loaded on start and stepped while running
    always_ff @(posedge clk) begin
        if (load) begin
            quo_q <= dividend;
            rem_q <= '0;
            dvs_q <= divisor;
            dbz_q <= (divisor == '0);
        end else if (state == CORE_RUN) begin
            quo_q <= {quo_q[DATA_W-2:0], fits};
            rem_q <= fits ? trial[DATA_W-1:0] : shifted[DATA_W-1:0];
        end
    end

    // with a zero divisor every step fits, so the quotient ends as all ones
    // and the remainder collects the whole dividend
    assign quotient    = quo_q;
    assign remainder   = rem_q;
    assign div_by_zero = dbz_q;
    assign core_done   = (state == CORE_DONE);

endmodule

`default_nettype wire

//--- div_signed_path.sv
`timescale 1ns/1ps
`default_nettype none

module div_signed_path import div_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,

    input  wire logic     start,
    input  wire div_req_t operands,

    output div_rsp_t      rsp,
    output logic          path_done
);

    logic [DATA_W-1:0] mag_dividend;
    logic [DATA_W-1:0] mag_divisor;
    logic [DATA_W-1:0] mag_quotient;
    logic [DATA_W-1:0] mag_remainder;
    logic              core_dbz;

    logic              neg_quotient;    // operand signs differ
    logic              neg_remainder;   // remainder follows dividend sign
    logic [DATA_W-1:0] dividend_q;      // original dividend for the zero-divisor result

    // magnitudes; 0x80000000 maps to itself, which is the right unsigned value
    assign mag_dividend = operands.dividend[DATA_W-1] ? -operands.dividend
                                                      : operands.dividend;
    assign mag_divisor  = operands.divisor[DATA_W-1] ? -operands.divisor
                                                     : operands.divisor;

    // sign info captured on the same edge the core loads
    always_ff @(posedge clk) begin
        if (start) begin
            neg_quotient  <= operands.dividend[DATA_W-1] ^ operands.divisor[DATA_W-1];
            neg_remainder <= operands.dividend[DATA_W-1];
            dividend_q    <= operands.dividend;
        end
    end

    div_iter_core i_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start),
        .dividend    (mag_dividend),
        .divisor     (mag_divisor),
        .quotient    (mag_quotient),
        .remainder   (mag_remainder),
        .div_by_zero (core_dbz),
        .core_done   (path_done)
    );

    // sign restore on the core output, adds no cycle
    always_comb begin
        rsp.div_by_zero = core_dbz;
        if (core_dbz) begin
            rsp.quotient  = '1;             // riscv: all ones
            rsp.remainder = dividend_q;
        end else begin
            rsp.quotient  = neg_quotient ? -mag_quotient : mag_quotient;
            rsp.remainder = neg_remainder ? -mag_remainder : mag_remainder;
        end
    end

endmodule

`default_nettype wire

//--- div_issue_merge.sv
`timescale 1ns/1ps
`default_nettype none

module div_issue_merge import div_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,

    input  wire logic     start,
    input  wire div_req_t req,

    output div_req_t      operands,         // held for both paths
    output logic          start_unsigned,
    output logic          start_signed,

    input  wire div_rsp_t rsp_unsigned,
    input  wire logic     done_unsigned,
    input  wire div_rsp_t rsp_signed,
    input  wire logic     done_signed,

    output div_rsp_t      rsp,
    output logic          done,
    output logic          busy
);

    logic accept;
    logic path_done;

    assign accept    = start & ~busy;               // starts while busy are dropped
    assign path_done = done_unsigned | done_signed;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            busy           <= 1'b0;
            start_unsigned <= 1'b0;
            start_signed   <= 1'b0;
            done           <= 1'b0;
            rsp            <= '0;
        end else begin
            start_unsigned <= accept && (req.op == DIV_UNSIGNED);
            start_signed   <= accept && (req.op == DIV_SIGNED);
            done           <= path_done;            // one-cycle pulse

            if (accept) begin
                busy <= 1'b1;
            end else if (path_done) begin
                busy <= 1'b0;                       // drops with done
            end

            // only one path runs at a time, signed wins if both ever fire
            if (path_done) begin
                rsp <= done_signed ? rsp_signed : rsp_unsigned;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            operands <= req;
        end
    end

endmodule

`default_nettype wire

//--- div_alu.sv
`timescale 1ns/1ps
`default_nettype none

module div_alu import div_pkg::*; (
    input  wire logic     clk,
    input  wire logic     arst_n,

    input  wire logic     start,
    input  wire div_req_t req,

    output div_rsp_t      rsp,
    output logic          done,
    output logic          busy
);

    div_req_t operands;
    logic     start_unsigned;
    logic     start_signed;

    div_rsp_t rsp_unsigned;
    div_rsp_t rsp_signed;
    logic     done_unsigned;
    logic     done_signed;

    logic [DATA_W-1:0] uns_quotient;
    logic [DATA_W-1:0] uns_remainder;
    logic              uns_dbz;

    div_issue_merge i_issue_merge (
        .clk            (clk),
        .arst_n         (arst_n),
        .start          (start),
        .req            (req),
        .operands       (operands),
        .start_unsigned (start_unsigned),
        .start_signed   (start_signed),
        .rsp_unsigned   (rsp_unsigned),
        .done_unsigned  (done_unsigned),
        .rsp_signed     (rsp_signed),
        .done_signed    (done_signed),
        .rsp            (rsp),
        .done           (done),
        .busy           (busy)
    );

    // unsigned path is the bare core
    div_iter_core i_unsigned_core (
        .clk         (clk),
        .arst_n      (arst_n),
        .start       (start_unsigned),
        .dividend    (operands.dividend),
        .divisor     (operands.divisor),
        .quotient    (uns_quotient),
        .remainder   (uns_remainder),
        .div_by_zero (uns_dbz),
        .core_done   (done_unsigned)
    );

    assign rsp_unsigned = '{quotient: uns_quotient, remainder: uns_remainder,
                            div_by_zero: uns_dbz};

    div_signed_path i_signed_path (
        .clk       (clk),
        .arst_n    (arst_n),
        .start     (start_signed),
        .operands  (operands),
        .rsp       (rsp_signed),
        .path_done (done_signed)
    );

endmodule

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic arst_n
);

    localparam time HALF_PERIOD = 20ns;     // 40 ns clock
    localparam int  RESET_CYCLES = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;                      // release away from the active edge
    end

endmodule

`default_nettype wire

//--- tb_div_alu.sv
`timescale 1ns/1ps
`default_nettype none

module tb_div_alu import div_pkg::*; ();

    localparam int                SEED          = 32'hacd5;
    localparam int                N_RANDOM      = 40;
    localparam int                LATENCY       = 35;   // start cycle to done cycle
    localparam int                DONE_TIMEOUT  = 100;
    localparam int                RESET_TIMEOUT = 50;
    localparam logic [DATA_W-1:0] MOST_NEG      = {1'b1, {(DATA_W-1){1'b0}}};

    logic     clk;
    logic     arst_n;
    logic     start;
    div_req_t req;
    div_rsp_t rsp;
    logic     done;
    logic     busy;

    int checks;
    int check_errors;
    int timeout_errors;

    tb_clk_gen i_clk_gen (
        .clk    (clk),
        .arst_n (arst_n)
    );

    div_alu i_dut (
        .clk    (clk),
        .arst_n (arst_n),
        .start  (start),
        .req    (req),
        .rsp    (rsp),
        .done   (done),
        .busy   (busy)
    );

    // expected result straight from the riscv division rules
    function automatic div_rsp_t model_rsp(input div_req_t r);
        div_rsp_t                 m;
        logic signed [DATA_W-1:0] sa;
        logic signed [DATA_W-1:0] sb;
        sa = r.dividend;
        sb = r.divisor;
        m  = '0;
        if (r.divisor == '0) begin
            m.quotient    = '1;
            m.remainder   = r.dividend;
            m.div_by_zero = 1'b1;
        end else if (r.op == DIV_UNSIGNED) begin
            m.quotient  = r.dividend / r.divisor;
            m.remainder = r.dividend % r.divisor;
        end else if (r.dividend == MOST_NEG && r.divisor == '1) begin
            m.quotient  = r.dividend;       // signed overflow case
            m.remainder = '0;
        end else begin
            m.quotient  = sa / sb;          // truncates toward zero
            m.remainder = sa % sb;          // sign of the dividend
        end
        return m;
    endfunction

    function automatic div_req_t make_req(input div_op_e op, input logic [DATA_W-1:0] dvd,
                                          input logic [DATA_W-1:0] dvs);
        div_req_t r;
        r.op       = op;
        r.dividend = dvd;
        r.divisor  = dvs;
        return r;
    endfunction

    task automatic check_rsp(input string name, input div_rsp_t exp, input div_rsp_t act);
        checks++;
        if (act !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s expected q=%h r=%h dbz=%b actual q=%h r=%h dbz=%b",
                     name, exp.quotient, exp.remainder, exp.div_by_zero,
                     act.quotient, act.remainder, act.div_by_zero);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            check_errors++;
            $display("CHECK FAILED %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_latency(input string name, input int exp, input int act);
        checks++;
        if (act != exp) begin
            check_errors++;
            $display("CHECK FAILED %s latency expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic report_timeout(input string name, input int limit);
        timeout_errors++;
        $display("%s: timed out after %0d cycles waiting for the DUT", name, limit);
    endtask

    task automatic idle(input int n);
        start = 1'b0;
        for (int k = 0; k < n; k++) begin
            @(negedge clk);
        end
    endtask

    // drive a request, it is sampled on the next rising edge
    task automatic launch(input div_req_t r);
        start = 1'b1;
        req   = r;
    endtask

    // counts falling edges until done, start is dropped after the first one
    task automatic wait_done(input string name, output int cycles, output bit seen);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            start = 1'b0;
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (!seen) begin
            report_timeout(name, DONE_TIMEOUT);
        end
    endtask

    task automatic collect(input string name, input div_req_t r);
        div_rsp_t exp;
        int       cycles;
        bit       seen;
        exp = model_rsp(r);
        wait_done(name, cycles, seen);
        if (seen) begin
            check_rsp(name, exp, rsp);
            check_flag({name, " busy at done"}, 1'b0, busy);
            check_latency(name, LATENCY, cycles);
        end
    endtask

    initial begin
        div_req_t          a;
        div_req_t          b;
        div_rsp_t          exp;
        div_op_e           op;
        logic [DATA_W-1:0] dvd;
        logic [DATA_W-1:0] dvs;
        int                cycles;
        bit                seen;

        start          = 1'b0;
        req            = '0;
        checks         = 0;
        check_errors   = 0;
        timeout_errors = 0;
        void'($urandom(SEED));

        cycles = 0;
        while (arst_n !== 1'b1 && cycles < RESET_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (arst_n !== 1'b1) begin
            report_timeout("reset release", RESET_TIMEOUT);
        end
        check_flag("reset done", 1'b0, done);
        check_flag("reset busy", 1'b0, busy);
        check_rsp("reset rsp", '0, rsp);

        // random unsigned, divisor width varies so quotients spread out
        for (int i = 0; i < N_RANDOM; i++) begin
            dvd = $urandom;
            dvs = $urandom >> ($urandom % 32);
            if (dvs == '0) begin
                dvs = 1;
            end
            a = make_req(DIV_UNSIGNED, dvd, dvs);
            launch(a);
            collect($sformatf("unsigned %0d", i), a);
            idle($urandom % 3);
        end

        // random signed, all four sign combinations in turn
        for (int i = 0; i < N_RANDOM; i++) begin
            dvd = $urandom;
            dvs = $urandom >> ($urandom % 32);
            dvd[DATA_W-1] = i[0];
            if (dvs == '0) begin
                dvs = 1;
            end
            if (i[1]) begin
                dvs = -dvs;
            end
            a = make_req(DIV_SIGNED, dvd, dvs);
            launch(a);
            collect($sformatf("signed %0d", i), a);
            idle($urandom % 3);
        end

        // divide by zero in both modes
        for (int i = 0; i < 8; i++) begin
            dvd = $urandom;
            op  = DIV_UNSIGNED;
            if (i[0]) begin
                op = DIV_SIGNED;
            end
            a = make_req(op, dvd, '0);
            launch(a);
            collect($sformatf("div by zero %0d", i), a);
        end

        // signed overflow, and the same bits unsigned
        a = make_req(DIV_SIGNED, MOST_NEG, '1);
        launch(a);
        collect("signed overflow", a);
        a = make_req(DIV_UNSIGNED, MOST_NEG, '1);
        launch(a);
        collect("unsigned most neg", a);
        idle(2);

        // second start while busy must be dropped
        a = make_req(DIV_UNSIGNED, $urandom, 32'd7);
        b = make_req(DIV_SIGNED, a.dividend ^ 32'h5a5a_0001, 32'hffff_fffd);
        exp = model_rsp(a);
        launch(a);
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end else begin
                check_flag("busy while running", 1'b1, busy);
                start = (cycles == 5);      // one stray start mid-run
                req   = (cycles == 5) ? b : a;
            end
        end
        start = 1'b0;
        if (!seen) begin
            report_timeout("start while busy", DONE_TIMEOUT);
        end else begin
            check_rsp("start while busy", exp, rsp);
            check_latency("start while busy", LATENCY, cycles);
        end
        cycles = 0;
        seen   = 1'b0;
        while (!seen && cycles < DONE_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (done === 1'b1) begin
                seen = 1'b1;
            end
        end
        if (seen) begin
            check_errors++;
            $display("start while busy: a second done appeared, the dropped start was run");
        end
        check_flag("busy after dropped start", 1'b0, busy);

        // new start in the done cycle of the previous one
        a = make_req(DIV_SIGNED, $urandom, $urandom >> 20);
        b = make_req(DIV_UNSIGNED, $urandom, $urandom >> 12);
        launch(a);
        collect("back to back first", a);
        launch(b);
        collect("back to back second", b);
        idle(2);

        $display("checks %0d, check errors %0d, timeouts %0d",
                 checks, check_errors, timeout_errors);
        if (check_errors == 0 && timeout_errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- div_alu.f
div_pkg.sv
div_iter_core.sv
div_signed_path.sv
div_issue_merge.sv
div_alu.sv
tb_clk_gen.sv
tb_div_alu.sv

//--- run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass line in the output
cd "$(dirname "$0")" &&
verilator --binary --timing --timescale 1ns/1ps -f div_alu.f \
    --top-module tb_div_alu -o sim_div_alu &&
./obj_dir/sim_div_alu | tee /dev/stderr | grep "RESULT: PASS" > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
